//--- wfd_master_top.f
common/wfd_pkg.sv
common/chan_stream_if.sv
trigger/trigger_manager.sv
trigger/fill_num_fifo.sv
logic/chan_rx_arbiter.sv
logic/daq_event_builder.sv
logic/wfd_master_top.sv
verif/wfd_master_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module wfd_master_tb -Mdir obj_dir -f wfd_master_top.f > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vwfd_master_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "testbench reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run ended without a result line"
    exit 1
fi
exit 0

//--- verif/wfd_master_tb.sv
// end to end check of the event path; assumes the default two channels and five trigger lines
`default_nettype none
`timescale 1ns/1ns

module wfd_master_tb;

    localparam int N_EVENTS = 5;     // fill numbers stay below 16 for the length tables
    localparam int WAIT_MAX = 200;   // cycles allowed for one channel handshake
    localparam int RUN_MAX  = 3000;  // cycles allowed for every event to drain

    logic                                    clk125;
    logic                                    arst_n     = 1'b0;
    logic                                    trigger    = 1'b0;
    logic                                    accept_exp = 1'b0;  // trigger should be taken
    logic [wfd_pkg::DEF_NUM_TRIG-1:0]        chan_done  = '0;
    logic [wfd_pkg::DEF_NUM_TRIG-1:0]        acq_trigs;
    logic                                    c0_valid   = 1'b0;
    logic                                    c0_ready;
    logic                                    c0_last    = 1'b0;
    logic [wfd_pkg::CHAN_DATA_W-1:0]         c0_data    = '0;
    logic                                    c1_valid   = 1'b0;
    logic                                    c1_ready;
    logic                                    c1_last    = 1'b0;
    logic [wfd_pkg::CHAN_DATA_W-1:0]         c1_data    = '0;
    logic                                    daq_valid;
    logic                                    daq_header;
    logic                                    daq_trailer;
    logic [wfd_pkg::DAQ_W-1:0]               daq_data;
    logic                                    daq_ready  = 1'b0;

    int                 seed       = 32'h134eb337;
    int                 len0 [16]  = '{default: 0};  // words sent per fill, channel 0
    int                 len1 [16]  = '{default: 0};
    wfd_pkg::fill_num_t exp_fill   = 24'd1;  // next header fill number
    wfd_pkg::fill_num_t cur_fill   = '0;     // fill of the open event
    logic               in_event   = 1'b0;
    logic               frame_open = 1'b0;   // channel frame started but not ended
    logic [3:0]         open_tag   = '0;
    int                 cnt0       = 0;      // payload words seen this event
    int                 cnt1       = 0;
    int                 ev_count   = 0;      // trailers seen
    logic               is_hdr;
    logic               is_pay;
    logic               is_trl;
    logic [3:0]         pay_tag;
    int                 pay_cnt;
    int                 pay_len;
    logic [63:0]        exp_pay;
    logic [63:0]        exp_trl;

    wfd_master_top wfd_master_top_inst (.*);

    initial begin
        clk125 = 1'b0;
        forever #5 clk125 = ~clk125;
    end

    // roughly one stall in four on the DAQ link
    always @(posedge clk125) begin
        daq_ready <= ($random(seed) & 3) != 0;
    end

    // channel word: last flag, channel, low fill bits, word index
    function automatic logic [31:0] make_word(input int ch, input int fill, input int k,
                                              input logic last);
        make_word = {last, 3'(ch), 12'(fill), 16'(k)};
    endfunction

    function automatic logic chan_ready(input int ch);
        chan_ready = (ch == 0) ? c0_ready : c1_ready;
    endfunction

    task automatic drive_chan(input int ch, input logic v, input logic [31:0] d, input logic l);
        if (ch == 0) begin
            c0_valid <= v;
            c0_data  <= d;
            c0_last  <= l;
        end else begin
            c1_valid <= v;
            c1_data  <= d;
            c1_last  <= l;
        end
    endtask

    task automatic send_frame(input int ch, input int fill, input int len);
        int   gap;
        int   waited;
        logic last;
        for (int k = 0; k < len; k++) begin
            gap  = $random(seed) & 3;
            last = (k == len - 1);
            if (gap != 0) begin
                drive_chan(ch, 1'b0, '0, 1'b0);  // idle gap inside the frame
                repeat (gap) @(posedge clk125);
            end
            drive_chan(ch, 1'b1, make_word(ch, fill, k, last), last);
            waited = 0;
            do begin
                @(posedge clk125);
                waited++;
            end while (!chan_ready(ch) && waited < WAIT_MAX);
            if (!chan_ready(ch)) begin
                $display("timeout waiting for ready on channel %0d", ch);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
        drive_chan(ch, 1'b0, '0, 1'b0);
    endtask

    // both channel frames of one event, run side by side
    task automatic send_event(input int fill);
        len0[fill] = 1 + ($random(seed) & 3);
        len1[fill] = 1 + ($random(seed) & 3);
        fork
            send_frame(0, fill, len0[fill]);
            send_frame(1, fill, len1[fill]);
        join
    endtask

    task automatic fire_trigger();
        @(posedge clk125);
        trigger    <= 1'b1;
        accept_exp <= 1'b1;
        chan_done  <= '0;  // channels start acquiring
        @(posedge clk125);
        trigger    <= 1'b0;
        accept_exp <= 1'b0;
    endtask

    task automatic busy_triggers(input int n);
        repeat (n) begin
            @(posedge clk125);
            trigger <= 1'b1;  // manager busy, must be dropped
        end
        @(posedge clk125);
        trigger <= 1'b0;
    endtask

    task automatic release_done();
        @(posedge clk125);
        chan_done <= '1;
        repeat (2) @(posedge clk125);  // fill push and busy exit
    endtask

    task automatic wait_events();
        int waited;
        waited = 0;
        while (ev_count < N_EVENTS && waited < RUN_MAX) begin
            @(posedge clk125);
            waited++;
        end
        if (ev_count < N_EVENTS) begin
            $display("timeout waiting for %0d DAQ events, only %0d seen", N_EVENTS, ev_count);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // DAQ side scoreboard
    assign is_hdr  = daq_valid && daq_ready && daq_header;
    assign is_trl  = daq_valid && daq_ready && daq_trailer;
    assign is_pay  = daq_valid && daq_ready && !daq_header && !daq_trailer;
    assign pay_tag = daq_data[35:32];
    assign pay_cnt = (pay_tag == 4'd1) ? cnt1 : cnt0;
    assign pay_len = (pay_tag == 4'd1) ? len1[cur_fill[3:0]] : len0[cur_fill[3:0]];
    assign exp_pay = {28'h0, pay_tag,
                      make_word(int'(pay_tag), int'(cur_fill), pay_cnt, (pay_cnt + 1) == pay_len)};
    assign exp_trl = {8'h0, 24'(len0[cur_fill[3:0]] + len1[cur_fill[3:0]]), 8'h0, cur_fill};

    always @(posedge clk125) begin
        if (is_hdr) begin
            in_event   <= 1'b1;
            cur_fill   <= daq_data[23:0];
            exp_fill   <= exp_fill + 1'b1;
            cnt0       <= 0;
            cnt1       <= 0;
            frame_open <= 1'b0;
        end else if (is_pay) begin
            if (pay_tag == 4'd1) begin
                cnt1 <= cnt1 + 1;
            end else begin
                cnt0 <= cnt0 + 1;
            end
            frame_open <= !daq_data[31];  // bit 31 flags the frame's last word
            open_tag   <= pay_tag;
        end else if (is_trl) begin
            in_event <= 1'b0;
            ev_count <= ev_count + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk125) !arst_n |=> (acq_trigs == '0 && !daq_valid))
        else begin
            $display("ERR acq_trigs %h daq_valid %h after reset",
                     $sampled(acq_trigs), $sampled(daq_valid));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_trig_taken: assert property (@(posedge clk125) disable iff (!arst_n)
        (trigger && accept_exp) |=> (acq_trigs == '1))
        else begin
            $display("ERR acq_trigs got %h exp 1f", $sampled(acq_trigs));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_trig_quiet: assert property (@(posedge clk125) disable iff (!arst_n)
        !(trigger && accept_exp) |=> (acq_trigs == '0))
        else begin
            $display("ERR acq_trigs got %h exp 00", $sampled(acq_trigs));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_daq_hold: assert property (@(posedge clk125) disable iff (!arst_n)
        (daq_valid && !daq_ready) |=> (daq_valid && daq_data == $past(daq_data)
                                       && daq_header == $past(daq_header)
                                       && daq_trailer == $past(daq_trailer)))
        else begin
            $display("ERR daq_data changed while stalled, now %h hdr %h trl %h",
                     $sampled(daq_data), $sampled(daq_header), $sampled(daq_trailer));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_header: assert property (@(posedge clk125) disable iff (!arst_n)
        is_hdr |-> (!in_event && daq_data == 64'(exp_fill)))
        else begin
            $display("ERR daq_data header got %h exp %h, open event %h",
                     $sampled(daq_data), 64'($sampled(exp_fill)), $sampled(in_event));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_payload: assert property (@(posedge clk125) disable iff (!arst_n)
        is_pay |-> (in_event && pay_tag < 4'd2 && (!frame_open || pay_tag == open_tag)
                    && daq_data == exp_pay))
        else begin
            $display("ERR daq_data payload got %h exp %h, open tag %h",
                     $sampled(daq_data), $sampled(exp_pay), $sampled(open_tag));
            $display("Simulation FAILED");
            $fatal(1);
        end

    a_trailer: assert property (@(posedge clk125) disable iff (!arst_n)
        is_trl |-> (in_event && !frame_open && cnt0 == len0[cur_fill[3:0]]
                    && cnt1 == len1[cur_fill[3:0]] && daq_data == exp_trl))
        else begin
            $display("ERR daq_data trailer got %h exp %h, words c0 %h c1 %h",
                     $sampled(daq_data), $sampled(exp_trl), $sampled(cnt0), $sampled(cnt1));
            $display("Simulation FAILED");
            $fatal(1);
        end

    initial begin
        repeat (5) @(posedge clk125);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk125);
        // one event at a time, extra triggers offered while busy
        for (int e = 1; e <= 2; e++) begin
            fire_trigger();
            busy_triggers(4);
            release_done();
            send_event(e);
        end
        // queue the remaining fill numbers before any channel data
        for (int e = 3; e <= N_EVENTS; e++) begin
            fire_trigger();
            release_done();
        end
        for (int e = 3; e <= N_EVENTS; e++) begin
            send_event(e);
        end
        wait_events();
        repeat (20) @(posedge clk125);  // any extra event would show up here
        if (ev_count != N_EVENTS || daq_valid !== 1'b0) begin
            $display("ERR ev_count got %h exp %h, daq_valid %h", ev_count, N_EVENTS, daq_valid);
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- logic/wfd_master_top.sv
// event path top; only c0 and c1 channel ports exist, so NUM_CHAN must stay 2
`default_nettype none
`timescale 1ns/1ns

module wfd_master_top #(
    parameter int NUM_CHAN   = wfd_pkg::DEF_NUM_CHAN,
    parameter int NUM_TRIG   = wfd_pkg::DEF_NUM_TRIG,
    parameter int FIFO_DEPTH = wfd_pkg::DEF_FIFO_DEPTH
) (
    input  logic                            clk125,
    input  logic                            arst_n,
    input  logic                            trigger,
    input  logic [NUM_TRIG-1:0]             chan_done,
    output logic [NUM_TRIG-1:0]             acq_trigs,
    input  logic                            c0_valid,  // channel 0 readout link
    output logic                            c0_ready,
    input  logic                            c0_last,
    input  logic [wfd_pkg::CHAN_DATA_W-1:0] c0_data,
    input  logic                            c1_valid,  // channel 1 readout link
    output logic                            c1_ready,
    input  logic                            c1_last,
    input  logic [wfd_pkg::CHAN_DATA_W-1:0] c1_data,
    output logic                            daq_valid,  // DAQ link side
    output logic                            daq_header,
    output logic                            daq_trailer,
    output logic [wfd_pkg::DAQ_W-1:0]       daq_data,
    input  logic                            daq_ready
);

    // manager to fill FIFO
    logic               tm_fill_valid;
    logic               tm_fill_ready;
    wfd_pkg::fill_num_t tm_fill_num;

    // fill FIFO to builder
    logic               fifo_fill_valid;
    logic               fifo_fill_ready;
    wfd_pkg::fill_num_t fifo_fill_num;

    // channel links packed for the arbiter
    logic [NUM_CHAN-1:0]             chan_valid;
    logic [NUM_CHAN-1:0]             chan_ready;
    logic [NUM_CHAN-1:0]             chan_last;
    logic [wfd_pkg::CHAN_DATA_W-1:0] chan_data [NUM_CHAN];

    chan_stream_if chan_bus ();  // arbiter to builder

    assign chan_valid   = {c1_valid, c0_valid};
    assign chan_last    = {c1_last, c0_last};
    assign chan_data[0] = c0_data;
    assign chan_data[1] = c1_data;
    assign c0_ready     = chan_ready[0];
    assign c1_ready     = chan_ready[1];

    trigger_manager #(
        .NUM_TRIG (NUM_TRIG)
    ) trigger_manager_inst (
        .clk125     (clk125),
        .arst_n     (arst_n),
        .trigger    (trigger),
        .chan_done  (chan_done),
        .acq_trigs  (acq_trigs),
        .fill_valid (tm_fill_valid),
        .fill_ready (tm_fill_ready),
        .fill_num   (tm_fill_num)
    );

    fill_num_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fill_num_fifo_inst (
        .clk125    (clk125),
        .arst_n    (arst_n),
        .in_valid  (tm_fill_valid),
        .in_ready  (tm_fill_ready),
        .in_fill   (tm_fill_num),
        .out_valid (fifo_fill_valid),
        .out_ready (fifo_fill_ready),
        .out_fill  (fifo_fill_num)
    );

    chan_rx_arbiter #(
        .NUM_CHAN (NUM_CHAN)
    ) chan_rx_arbiter_inst (
        .clk125   (clk125),
        .arst_n   (arst_n),
        .in_valid (chan_valid),
        .in_ready (chan_ready),
        .in_last  (chan_last),
        .in_data  (chan_data),
        .out      (chan_bus.src)
    );

    daq_event_builder #(
        .NUM_CHAN (NUM_CHAN)
    ) daq_event_builder_inst (
        .clk125      (clk125),
        .arst_n      (arst_n),
        .fill_valid  (fifo_fill_valid),
        .fill_ready  (fifo_fill_ready),
        .fill_num    (fifo_fill_num),
        .chan        (chan_bus.dst),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

endmodule

`default_nettype wire

//--- logic/daq_event_builder.sv
// one event per fill number, closed after NUM_CHAN frames; output word is registered
`default_nettype none
`timescale 1ns/1ns

module daq_event_builder #(
    parameter int NUM_CHAN = wfd_pkg::DEF_NUM_CHAN
) (
    input  logic                      clk125,
    input  logic                      arst_n,
    input  logic                      fill_valid,
    output logic                      fill_ready,
    input  wfd_pkg::fill_num_t        fill_num,
    chan_stream_if.dst                chan,
    output logic                      daq_valid,
    output logic                      daq_header,
    output logic                      daq_trailer,
    output logic [wfd_pkg::DAQ_W-1:0] daq_data,
    input  logic                      daq_ready
);

    localparam int FR_W = $clog2(NUM_CHAN + 1);

    typedef enum logic [1:0] {
        S_HEAD,     // wait for a fill number
        S_PAYLOAD,  // copy channel words
        S_TRAIL     // emit trailer
    } state_t;

    state_t             state;
    wfd_pkg::fill_num_t fill_q;       // fill number of the open event
    wfd_pkg::fill_num_t word_cnt;     // payload words so far
    logic [FR_W-1:0]    frames_done;  // channel frames ended
    logic               out_free;     // output register empty or draining now
    logic               fill_xfer;
    logic               chan_xfer;

    assign out_free   = !daq_valid || daq_ready;
    assign fill_ready = (state == S_HEAD) && out_free;
    assign chan.ready = (state == S_PAYLOAD) && out_free;
    assign fill_xfer  = fill_valid && fill_ready;
    assign chan_xfer  = chan.valid && chan.ready;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state       <= S_HEAD;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
            word_cnt    <= '0;
            frames_done <= '0;
        end else begin
            if (daq_ready) begin
                daq_valid   <= 1'b0;  // reloaded below if a new word is ready
                daq_header  <= 1'b0;
                daq_trailer <= 1'b0;
            end
            case (state)
                S_HEAD: begin
                    if (fill_xfer) begin
                        daq_valid   <= 1'b1;
                        daq_header  <= 1'b1;
                        word_cnt    <= '0;
                        frames_done <= '0;
                        state       <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (chan_xfer) begin
                        daq_valid <= 1'b1;
                        word_cnt  <= word_cnt + 1'b1;
                        if (chan.last) begin
                            frames_done <= frames_done + 1'b1;
                            if (frames_done == FR_W'(NUM_CHAN - 1)) begin
                                state <= S_TRAIL;  // every channel has closed
                            end
                        end
                    end
                end
                S_TRAIL: begin
                    if (out_free) begin
                        daq_valid   <= 1'b1;
                        daq_trailer <= 1'b1;
                        state       <= S_HEAD;
                    end
                end
                default: state <= S_HEAD;
            endcase
        end
    end

    // payload registers, no reset
    always_ff @(posedge clk125) begin
        if (fill_xfer) begin
            fill_q   <= fill_num;
            daq_data <= wfd_pkg::DAQ_W'(fill_num);  // header, fill in 23:0
        end else if (chan_xfer) begin
            daq_data <= wfd_pkg::DAQ_W'(chan.word);  // tag 35:32, data 31:0
        end else if (state == S_TRAIL && out_free) begin
            daq_data <= wfd_pkg::DAQ_W'({word_cnt, 8'h00, fill_q});  // count 55:32
        end
    end

    // header and trailer flags exclusive on every held word
    a_hdr_trl_excl: assert property (@(posedge clk125) disable iff (!arst_n)
        daq_valid |-> !(daq_header && daq_trailer));

endmodule

`default_nettype wire

//--- logic/chan_rx_arbiter.sv
// frame-level round robin; a channel must hold valid once raised, first word passes same cycle
`default_nettype none
`timescale 1ns/1ns

module chan_rx_arbiter #(
    parameter int NUM_CHAN = wfd_pkg::DEF_NUM_CHAN
) (
    input  logic                            clk125,
    input  logic                            arst_n,
    input  logic [NUM_CHAN-1:0]             in_valid,
    output logic [NUM_CHAN-1:0]             in_ready,
    input  logic [NUM_CHAN-1:0]             in_last,
    input  logic [wfd_pkg::CHAN_DATA_W-1:0] in_data [NUM_CHAN],
    chan_stream_if.src                      out
);

    localparam int IDX_W = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

    logic             busy;      // frame open, grant locked
    logic [IDX_W-1:0] sel_q;     // locked grant
    logic [IDX_W-1:0] last_idx;  // last channel whose frame ended
    logic [IDX_W-1:0] pick;      // search result when idle
    logic [IDX_W-1:0] sel;       // grant in use this cycle
    logic             found;
    logic             active;
    logic             xfer;

    // search starts just after the last granted channel
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = sel_q;
        for (int k = NUM_CHAN; k >= 1; k--) begin  // nearest wins, so walk from far end
            cand = (int'(last_idx) + k) % NUM_CHAN;
            if (in_valid[cand]) begin
                found = 1'b1;
                pick  = IDX_W'(cand);
            end
        end
    end

    assign sel    = busy ? sel_q : pick;
    assign active = busy || found;

    // combinational mux, no added cycle
    assign out.valid     = active && in_valid[sel];
    assign out.last      = in_last[sel];
    assign out.word.chan = wfd_pkg::CHAN_ID_W'(sel);
    assign out.word.data = in_data[sel];
    assign xfer          = out.valid && out.ready;

    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            in_ready[i] = active && (sel == IDX_W'(i)) && out.ready;  // granted channel only
        end
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            sel_q    <= '0;
            last_idx <= IDX_W'(NUM_CHAN - 1);  // channel 0 searched first
        end else if (xfer && out.last) begin
            busy     <= 1'b0;  // frame closed, free for next search
            last_idx <= sel;
        end else if (!busy && found) begin
            busy  <= 1'b1;  // lock even when the sink stalls the first word
            sel_q <= pick;
        end
    end

    // grant stays put from first word to last, including the lock on an idle first word
    a_grant_held: assert property (@(posedge clk125) disable iff (!arst_n)
        (xfer && !out.last) |=> (busy && sel == $past(sel)));

endmodule

`default_nettype wire

//--- trigger/fill_num_fifo.sv
// fill number FIFO; output is combinational from the buffer, so write to read is one cycle
`default_nettype none
`timescale 1ns/1ns

module fill_num_fifo #(
    parameter int DEPTH = wfd_pkg::DEF_FIFO_DEPTH
) (
    input  logic               clk125,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  wfd_pkg::fill_num_t in_fill,
    output logic               out_valid,
    input  logic               out_ready,
    output wfd_pkg::fill_num_t out_fill
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wfd_pkg::fill_num_t mem [DEPTH];  // storage, no reset needed
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;        // occupancy
    logic               wr_en;
    logic               rd_en;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_fill  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk125) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_fill;
        end
    end

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                // wrap by compare, DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // when full the write slot is the oldest entry, a push offered then must not overwrite it
    a_no_write_full: assert property (@(posedge clk125) disable iff (!arst_n)
        (in_valid && count == CNT_W'(DEPTH) && !rd_en) |=> (out_fill == $past(out_fill)));

endmodule

`default_nettype wire

//--- trigger/trigger_manager.sv
// one trigger in flight; stays busy until its fill number is queued and all chan_done are high
`default_nettype none
`timescale 1ns/1ns

module trigger_manager #(
    parameter int NUM_TRIG = wfd_pkg::DEF_NUM_TRIG
) (
    input  logic                clk125,
    input  logic                arst_n,
    input  logic                trigger,     // request, sampled only when idle
    input  logic [NUM_TRIG-1:0] chan_done,   // per channel, acquisition finished
    output logic [NUM_TRIG-1:0] acq_trigs,   // one cycle go pulse to every channel
    output logic                fill_valid,
    input  logic                fill_ready,
    output wfd_pkg::fill_num_t  fill_num
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t             state;
    logic               go;         // acquisition pulse register
    logic               push_pend;  // fill number not yet taken by the FIFO
    wfd_pkg::fill_num_t fill_cnt;   // last issued fill number
    logic               push_done;

    assign acq_trigs  = {NUM_TRIG{go}};
    assign fill_valid = push_pend;
    assign fill_num   = fill_cnt;

    // push finished or finishing this edge
    assign push_done = !push_pend || fill_ready;

    always_ff @(posedge clk125 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            go        <= 1'b0;
            push_pend <= 1'b0;
            fill_cnt  <= '0;  // first accepted trigger gets 1
        end else begin
            go <= 1'b0;  // pulse lasts one cycle
            if (push_pend && fill_ready) begin
                push_pend <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (trigger) begin
                        // pulse and fill number come from the same accept
                        go        <= 1'b1;
                        push_pend <= 1'b1;
                        fill_cnt  <= fill_cnt + 1'b1;
                        state     <= BUSY;
                    end
                end
                BUSY: begin
                    if (push_done && (&chan_done)) begin
                        state <= IDLE;  // triggers seen while busy are dropped
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // channels must never see a two cycle go
    a_single_pulse: assert property (@(posedge clk125) disable iff (!arst_n)
        (|acq_trigs) |=> !(|acq_trigs));

endmodule

`default_nettype wire

//--- common/chan_stream_if.sv
// arbitrated channel stream; word and last must hold while valid is high and ready low
`default_nettype none
`timescale 1ns/1ns

interface chan_stream_if;

    logic                 valid;  // word on the bus
    logic                 ready;  // sink takes it this edge
    logic                 last;   // final word of a channel frame
    wfd_pkg::chan_word_t  word;   // tagged channel data

    // arbiter side
    modport src (
        output valid,
        output last,
        output word,
        input  ready
    );

    // event builder side
    modport dst (
        input  valid,
        input  last,
        input  word,
        output ready
    );

endinterface

`default_nettype wire

//--- common/wfd_pkg.sv
// shared widths and types for the event path; DAQ word layout assumes DAQ_W of 64
`default_nettype none

package wfd_pkg;

    // data path widths
    localparam int FILL_W      = 24;  // fill number, also trailer word count
    localparam int CHAN_DATA_W = 32;  // one channel readout word
    localparam int DAQ_W       = 64;  // DAQ link word
    localparam int CHAN_ID_W   = 4;   // channel tag in payload bits 35:32

    // defaults for the top level parameters
    localparam int DEF_NUM_CHAN   = 2;  // readout links c0, c1
    localparam int DEF_NUM_TRIG   = 5;  // acquisition lines to channel FPGAs
    localparam int DEF_FIFO_DEPTH = 4;  // pending fill numbers

    typedef logic [FILL_W-1:0] fill_num_t;

    // tag sits above data so a zero-extended copy lands on the payload layout
    typedef struct packed {
        logic [CHAN_ID_W-1:0]   chan;  // source channel index
        logic [CHAN_DATA_W-1:0] data;  // word as received
    } chan_word_t;

endpackage

`default_nettype wire
